//--- rtl/core_pkg.sv
//////////////////////////////////////////////////////////////////////
// Core package
// Widths, opcodes, ALU operations, the instruction union and the
// packets that travel between the three pipeline stages
//////////////////////////////////////////////////////////////////////

package core_pkg;

    localparam int XLEN      = 32;                // Data width
    localparam int REG_IDX_W = 5;                 // 32 architectural registers

    // Legal major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011; // Register-register
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // Register-immediate

    // funct3 codes shared by both formats
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL     = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // Normal R-type
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB only

    // ADDI x0, x0, 0
    localparam logic [31:0] NOP_INST = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,  // Signed compare
        ALU_SLL,
        ALU_SRL
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////
    // Instruction word views
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [6:0]           funct7;
        logic [REG_IDX_W-1:0] rs2;
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0]          imm;     // Sign bit at [11]
        logic [REG_IDX_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [REG_IDX_W-1:0] rd;
        logic [6:0]           opcode;
    } i_type_t;

    // Same 32 bits, two layouts
    typedef union packed {
        r_type_t r;
        i_type_t i;
    } inst_u;

    ////////////////////////////////////////////////////////////////////
    // Stage packets
    ////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fetch_t;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      op_a;      // rs1 after bypass
        logic [XLEN-1:0]      op_b_reg;  // rs2 after bypass
        logic [XLEN-1:0]      imm;       // Already sign-extended
        logic                 use_imm;
        alu_op_e              alu_op;
        logic                 write_en;
        logic                 illegal;
    } dec_t;

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      result;
        logic                 write_en;
        logic                 illegal;
    } exe_t;

    // Commit output, doubles as the register file write port
    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [REG_IDX_W-1:0] rd;
        logic [XLEN-1:0]      data;
        logic                 write_en;
        logic                 illegal;
    } commit_t;

    // Bubble contents, matching a decoded NOP with valid low
    localparam dec_t DEC_NOP = '{
        valid: 1'b0, pc: '0, rd: '0, op_a: '0, op_b_reg: '0, imm: '0,
        use_imm: 1'b1, alu_op: ALU_ADD, write_en: 1'b0, illegal: 1'b0
    };

    localparam exe_t EXE_NOP = '{
        valid: 1'b0, pc: '0, rd: '0, result: '0, write_en: 1'b0, illegal: 1'b0
    };

endpackage

//--- rtl/regfile.sv
//////////////////////////////////////////////////////////////////////
// Register file
// 32 x 32 bits, two combinational reads, one write, x0 hardwired
//////////////////////////////////////////////////////////////////////

module regfile (
    input  logic                             clock,
    input  logic                             reset,
    input  logic [core_pkg::REG_IDX_W-1:0]   rs1_idx,
    input  logic [core_pkg::REG_IDX_W-1:0]   rs2_idx,
    output logic [core_pkg::XLEN-1:0]        rs1_data,
    output logic [core_pkg::XLEN-1:0]        rs2_data,
    input  core_pkg::commit_t                wr
);

    logic [core_pkg::XLEN-1:0] regs [31:1];  // No storage behind x0

    // Write lands at the edge after commit is visible
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.write_en && (wr.rd != '0)) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Reads see the old value during a same-cycle write
    assign rs1_data = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign rs2_data = (rs2_idx == '0) ? '0 : regs[rs2_idx];

endmodule

//--- rtl/stage_decode.sv
//////////////////////////////////////////////////////////////////////
// Decode stage
// Decodes R and I formats, reads the register file and bypasses
// results still in flight in execute and result
//////////////////////////////////////////////////////////////////////

module stage_decode (
    input  logic              clock,
    input  logic              reset,
    input  core_pkg::fetch_t  fetch,
    input  core_pkg::exe_t    ex_fwd,   // One instruction ahead
    input  core_pkg::commit_t wb,       // Two instructions ahead
    output core_pkg::dec_t    dec
);

    core_pkg::inst_u           inst;
    logic [core_pkg::XLEN-1:0] rs1_rf;
    logic [core_pkg::XLEN-1:0] rs2_rf;
    core_pkg::alu_op_e         alu_op;
    logic                      use_imm;
    logic                      legal;

    // Newest in-flight value wins, execute before result
    function automatic logic [core_pkg::XLEN-1:0] bypass(
        input logic [core_pkg::REG_IDX_W-1:0] idx,
        input logic [core_pkg::XLEN-1:0]      rf_val,
        input core_pkg::exe_t                 ex,
        input core_pkg::commit_t              cm
    );
        logic [core_pkg::XLEN-1:0] val;
        val = rf_val;
        if (idx != '0) begin  // x0 stays zero
            if (ex.valid && ex.write_en && (ex.rd == idx)) begin
                val = ex.result;
            end else if (cm.valid && cm.write_en && (cm.rd == idx)) begin
                val = cm.data;  // Not yet in the register file
            end
        end
        return val;
    endfunction

    assign inst = fetch.valid ? fetch.inst : core_pkg::NOP_INST;  // Bubble decodes as NOP

    regfile u_regfile (
        .clock    (clock),
        .reset    (reset),
        .rs1_idx  (inst.r.rs1),
        .rs2_idx  (inst.r.rs2),   // Immediate bits for I-type, unused there
        .rs1_data (rs1_rf),
        .rs2_data (rs2_rf),
        .wr       (wb)
    );

    //////////////////////////////////////////////////////////////////////
    // Opcode and function decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        alu_op  = core_pkg::ALU_ADD;
        use_imm = 1'b0;
        legal   = 1'b0;
        case (inst.r.opcode)
            core_pkg::OPC_OP: begin
                // Alternate funct7 only with ADD/SUB
                legal = (inst.r.funct7 == core_pkg::F7_BASE) ||
                        ((inst.r.funct7 == core_pkg::F7_ALT) &&
                         (inst.r.funct3 == core_pkg::F3_ADD_SUB));
                case (inst.r.funct3)
                    core_pkg::F3_ADD_SUB: begin
                        alu_op = (inst.r.funct7 == core_pkg::F7_ALT) ? core_pkg::ALU_SUB
                                                                     : core_pkg::ALU_ADD;
                    end
                    core_pkg::F3_SLL: alu_op = core_pkg::ALU_SLL;
                    core_pkg::F3_SLT: alu_op = core_pkg::ALU_SLT;
                    core_pkg::F3_XOR: alu_op = core_pkg::ALU_XOR;
                    core_pkg::F3_SRL: alu_op = core_pkg::ALU_SRL;
                    core_pkg::F3_OR:  alu_op = core_pkg::ALU_OR;
                    core_pkg::F3_AND: alu_op = core_pkg::ALU_AND;
                    default:          legal  = 1'b0;  // SLTU
                endcase
            end
            core_pkg::OPC_OP_IMM: begin
                use_imm = 1'b1;
                legal   = 1'b1;
                case (inst.i.funct3)
                    core_pkg::F3_ADD_SUB: alu_op = core_pkg::ALU_ADD;
                    core_pkg::F3_SLT:     alu_op = core_pkg::ALU_SLT;
                    core_pkg::F3_XOR:     alu_op = core_pkg::ALU_XOR;
                    core_pkg::F3_OR:      alu_op = core_pkg::ALU_OR;
                    core_pkg::F3_AND:     alu_op = core_pkg::ALU_AND;
                    default:              legal  = 1'b0;  // Immediate shifts, SLTIU
                endcase
            end
            default: legal = 1'b0;  // Anything else is illegal
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Decode packet
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        dec.valid    = fetch.valid;
        dec.pc       = fetch.valid ? fetch.pc : '0;
        dec.rd       = inst.r.rd;
        dec.op_a     = bypass(inst.r.rs1, rs1_rf, ex_fwd, wb);
        dec.op_b_reg = bypass(inst.r.rs2, rs2_rf, ex_fwd, wb);
        dec.imm      = {{(core_pkg::XLEN-12){inst.i.imm[11]}}, inst.i.imm};
        dec.use_imm  = use_imm;
        dec.alu_op   = alu_op;
        dec.write_en = fetch.valid && legal && (inst.r.rd != '0);  // Illegal never writes
        dec.illegal  = fetch.valid && !legal;
    end

endmodule

//--- rtl/stage_execute.sv
//////////////////////////////////////////////////////////////////////
// Execute stage
// 32-bit ALU with register or immediate second operand
//////////////////////////////////////////////////////////////////////

module stage_execute (
    input  core_pkg::dec_t dec,
    output core_pkg::exe_t exe
);

    logic [core_pkg::XLEN-1:0] op_b;
    logic [core_pkg::XLEN-1:0] result;
    logic [4:0]                shamt;

    assign op_b  = dec.use_imm ? dec.imm : dec.op_b_reg;
    assign shamt = op_b[4:0];  // Upper bits of the shift amount ignored

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (dec.alu_op)
            core_pkg::ALU_ADD: result = dec.op_a + op_b;
            core_pkg::ALU_SUB: result = dec.op_a - op_b;
            core_pkg::ALU_AND: result = dec.op_a & op_b;
            core_pkg::ALU_OR:  result = dec.op_a | op_b;
            core_pkg::ALU_XOR: result = dec.op_a ^ op_b;
            core_pkg::ALU_SLT: begin
                // Signed compare, 0 or 1
                result = {{(core_pkg::XLEN-1){1'b0}}, ($signed(dec.op_a) < $signed(op_b))};
            end
            core_pkg::ALU_SLL: result = dec.op_a << shamt;
            core_pkg::ALU_SRL: result = dec.op_a >> shamt;  // Logical
            default:           result = '0;
        endcase
    end

    // Destination and flags ride along
    always_comb begin
        exe.valid    = dec.valid;
        exe.pc       = dec.pc;
        exe.rd       = dec.rd;
        exe.result   = result;
        exe.write_en = dec.write_en;
        exe.illegal  = dec.illegal;
    end

endmodule

//--- rtl/stage_result.sv
//////////////////////////////////////////////////////////////////////
// Result stage
// Forms the commit packet and write-back, counts retirements
//////////////////////////////////////////////////////////////////////

module stage_result (
    input  logic              clock,
    input  logic              reset,
    input  core_pkg::exe_t    exe,
    output core_pkg::commit_t commit,
    output logic [31:0]       retire_count
);

    // Write only for a valid, legal op
    always_comb begin
        commit.valid    = exe.valid;
        commit.pc       = exe.pc;
        commit.rd       = exe.rd;
        commit.data     = exe.result;
        commit.write_en = exe.valid && exe.write_en && !exe.illegal;  // x0 dropped in decode
        commit.illegal  = exe.valid && exe.illegal;
    end

    // Illegal instructions still retire
    always_ff @(posedge clock) begin
        if (reset) begin
            retire_count <= '0;
        end else if (exe.valid) begin
            retire_count <= retire_count + 32'd1;
        end
    end

endmodule

//--- rtl/core_top.sv
//////////////////////////////////////////////////////////////////////
// Core top level
// Three-stage in-order pipeline: decode, execute, result,
// with full bypass so the pipe never stalls
//////////////////////////////////////////////////////////////////////

module core_top (
    input  logic              clock,
    input  logic              reset,
    input  core_pkg::fetch_t  fetch,         // One instruction per valid cycle
    output core_pkg::commit_t commit,        // Two cycles after fetch
    output logic [31:0]       retire_count
);

    //////////////////////////////////////////////////////////////////////
    // Pipeline wires
    //////////////////////////////////////////////////////////////////////

    core_pkg::dec_t dec_d;   // Decode output
    core_pkg::dec_t dec_q;   // Decode/execute register
    core_pkg::exe_t exe_d;   // Execute output, also bypass source
    core_pkg::exe_t exe_q;   // Execute/result register

    //////////////////////////////////////////////////////////////////////
    // Decode
    //////////////////////////////////////////////////////////////////////

    stage_decode u_stage_decode (
        .clock  (clock),
        .reset  (reset),
        .fetch  (fetch),
        .ex_fwd (exe_d),    // Distance-1 bypass
        .wb     (commit),   // Distance-2 bypass and register write
        .dec    (dec_d)
    );

    //////////////////////////////////////////////////////////////////////
    // Decode/execute register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            dec_q <= core_pkg::DEC_NOP;  // NOP with valid low
        end else begin
            dec_q <= dec_d;              // Bubbles arrive already invalid
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Execute
    //////////////////////////////////////////////////////////////////////

    stage_execute u_stage_execute (
        .dec (dec_q),
        .exe (exe_d)
    );

    //////////////////////////////////////////////////////////////////////
    // Execute/result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            exe_q <= core_pkg::EXE_NOP;
        end else begin
            exe_q <= exe_d;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Result and commit
    //////////////////////////////////////////////////////////////////////

    // Commit drives the outside world and the register file together
    stage_result u_stage_result (
        .clock        (clock),
        .reset        (reset),
        .exe          (exe_q),
        .commit       (commit),
        .retire_count (retire_count)
    );

endmodule

//--- tests/core_asserts.sv
//////////////////////////////////////////////////////////////////////
// Core timing assertions
// Commit strobe against fetch strobe and x0 write protection
//////////////////////////////////////////////////////////////////////

module core_asserts (
    input logic              clock,
    input logic              reset,
    input core_pkg::fetch_t  fetch,
    input core_pkg::commit_t commit
);
    timeunit 1ns;
    timeprecision 1ps;

    // Pipe is empty right out of reset
    commit_idle_after_reset: assert property (
        @(posedge clock) ($past(reset) && !reset) |-> !commit.valid
    ) else $error("commit valid in first cycle after reset");

    // Fixed two-cycle latency, bubbles included
    commit_follows_fetch: assert property (
        @(posedge clock) (!reset && !$past(reset) && !$past(reset, 2))
            |-> (commit.valid == $past(fetch.valid, 2))
    ) else $error("commit valid does not match fetch valid two cycles earlier");

    no_write_to_x0: assert property (
        @(posedge clock) disable iff (reset)
            commit.valid |-> !(commit.write_en && (commit.rd == '0))
    ) else $error("commit writes register zero");

endmodule

bind core_top core_asserts u_core_asserts (
    .clock  (clock),
    .reset  (reset),
    .fetch  (fetch),
    .commit (commit)
);

//--- tests/core_checker.sv
//////////////////////////////////////////////////////////////////////
// Commit checker
// Queues expected commits and compares them with the core output
//////////////////////////////////////////////////////////////////////

module core_checker (
    input  logic              clock,
    input  logic              reset,
    input  core_pkg::commit_t commit,
    input  logic [31:0]       retire_count,
    input  logic              exp_valid,
    input  core_pkg::commit_t exp_commit,
    input  logic              end_check,
    input  logic [31:0]       expected_retires,
    output logic              check_done,
    output int                error_total
);
    timeunit 1ns;
    timeprecision 1ps;

    core_pkg::commit_t exp_q[$];  // In program order
    core_pkg::commit_t head;
    int                mismatch_errors;
    int                unexpected_errors;
    int                missing_errors;
    int                retire_errors;

    assign error_total = mismatch_errors + unexpected_errors + missing_errors + retire_errors;

    task automatic compare_field(input string name, input logic [31:0] pc,
                                 input logic [31:0] want, input logic [31:0] got);
        if (got !== want) begin
            mismatch_errors++;
            $display("FAIL %0t: pc %h %s expected %h got %h", $time, pc, name, want, got);
        end
    endtask

    task automatic compare_commit(input core_pkg::commit_t want);
        compare_field("pc", want.pc, want.pc, commit.pc);
        compare_field("rd", want.pc, {27'd0, want.rd}, {27'd0, commit.rd});
        compare_field("write_en", want.pc, {31'd0, want.write_en}, {31'd0, commit.write_en});
        compare_field("illegal", want.pc, {31'd0, want.illegal}, {31'd0, commit.illegal});
        if (!want.illegal) begin  // Data has no meaning for illegal ops
            compare_field("data", want.pc, want.data, commit.data);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Compare at each edge, pop before push
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset) begin
            exp_q.delete();
            mismatch_errors   = 0;
            unexpected_errors = 0;
            missing_errors    = 0;
            retire_errors     = 0;
            check_done        = 1'b0;
        end else begin
            if (commit.valid) begin
                if (exp_q.size() == 0) begin
                    unexpected_errors++;
                    $display("Unexpected commit at %0t for pc %h with nothing pending",
                             $time, commit.pc);
                end else begin
                    head = exp_q.pop_front();
                    compare_commit(head);
                end
            end
            if (exp_valid) exp_q.push_back(exp_commit);
            // End of run summary
            if (end_check && !check_done) begin
                if (exp_q.size() != 0) begin
                    missing_errors += exp_q.size();
                    $display("Missing commits: %0d instructions never committed", exp_q.size());
                end
                if (retire_count !== expected_retires) begin
                    retire_errors++;
                    $display("FAIL %0t: retire_count expected %0d got %0d",
                             $time, expected_retires, retire_count);
                end
                $display("Errors: mismatch %0d, unexpected %0d, missing %0d, retire %0d",
                         mismatch_errors, unexpected_errors, missing_errors, retire_errors);
                check_done = 1'b1;
            end
        end
    end

endmodule

//--- tests/core_tb.sv
//////////////////////////////////////////////////////////////////////
// Core testbench
// Streams a table of instructions into the pipeline and hands the
// expected commits to the checker
//////////////////////////////////////////////////////////////////////

module core_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // One stimulus row with its hand-computed commit
    typedef struct packed {
        logic        valid;
        logic [31:0] inst;
        logic [4:0]  rd;
        logic [31:0] data;
        logic        write_en;
        logic        illegal;
    } row_t;

    logic              clock;
    logic              reset;
    core_pkg::fetch_t  fetch;
    core_pkg::commit_t commit;
    logic [31:0]       retire_count;
    logic              exp_valid;      // Strobe into the checker queue
    core_pkg::commit_t exp_commit;
    logic              end_check;
    logic [31:0]       valid_rows;
    logic              check_done;
    int                error_total;
    int                cycle_count;
    row_t              stim_rows[$];

    always #10 clock = ~clock;  // 20 ns period

    core_top u_core_top (
        .clock        (clock),
        .reset        (reset),
        .fetch        (fetch),
        .commit       (commit),
        .retire_count (retire_count)
    );

    core_checker u_core_checker (
        .clock            (clock),
        .reset            (reset),
        .commit           (commit),
        .retire_count     (retire_count),
        .exp_valid        (exp_valid),
        .exp_commit       (exp_commit),
        .end_check        (end_check),
        .expected_retires (valid_rows),
        .check_done       (check_done),
        .error_total      (error_total)
    );

    //////////////////////////////////////////////////////////////////////
    // Instruction encoders and row builders
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};  // OP
    endfunction

    function automatic logic [31:0] i_word(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};      // OP-IMM
    endfunction

    // x0 as destination never writes
    task automatic legal_row(input logic [31:0] inst, input logic [4:0] rd,
                             input logic [31:0] data);
        stim_rows.push_back('{valid: 1'b1, inst: inst, rd: rd, data: data,
                              write_en: (rd != 5'd0), illegal: 1'b0});
    endtask

    task automatic illegal_row(input logic [31:0] inst, input logic [4:0] rd);
        stim_rows.push_back('{valid: 1'b1, inst: inst, rd: rd, data: 32'd0,
                              write_en: 1'b0, illegal: 1'b1});
    endtask

    // Word on the bus with valid low, must be ignored
    task automatic bubble_row(input logic [31:0] inst);
        stim_rows.push_back('{valid: 1'b0, inst: inst, rd: 5'd0, data: 32'd0,
                              write_en: 1'b0, illegal: 1'b0});
    endtask

    task automatic build_table();
        legal_row(i_word(3'b000, 5'd1, 5'd0, 12'd5), 5'd1, 32'd5);
        legal_row(i_word(3'b000, 5'd2, 5'd0, 12'hFFD), 5'd2, 32'hFFFF_FFFD);  // -3
        legal_row(i_word(3'b000, 5'd3, 5'd0, 12'd36), 5'd3, 32'd36);         // Shift 36
        bubble_row(i_word(3'b000, 5'd1, 5'd0, 12'd99));
        // R-type ALU set
        legal_row(r_word(7'h00, 3'b000, 5'd4, 5'd1, 5'd2), 5'd4, 32'd2);
        legal_row(r_word(7'h20, 3'b000, 5'd5, 5'd1, 5'd2), 5'd5, 32'd8);
        legal_row(r_word(7'h00, 3'b111, 5'd6, 5'd1, 5'd2), 5'd6, 32'd5);
        legal_row(r_word(7'h00, 3'b110, 5'd7, 5'd1, 5'd2), 5'd7, 32'hFFFF_FFFD);
        legal_row(r_word(7'h00, 3'b100, 5'd8, 5'd1, 5'd2), 5'd8, 32'hFFFF_FFF8);
        legal_row(r_word(7'h00, 3'b010, 5'd9, 5'd2, 5'd1), 5'd9, 32'd1);      // -3 < 5
        legal_row(r_word(7'h00, 3'b010, 5'd10, 5'd1, 5'd2), 5'd10, 32'd0);
        legal_row(r_word(7'h00, 3'b001, 5'd11, 5'd1, 5'd3), 5'd11, 32'h50);   // By 4
        legal_row(r_word(7'h00, 3'b101, 5'd12, 5'd2, 5'd3), 5'd12, 32'h0FFF_FFFF);
        // Immediates, sign-extended
        legal_row(i_word(3'b000, 5'd13, 5'd1, 12'hFFF), 5'd13, 32'd4);
        legal_row(i_word(3'b111, 5'd14, 5'd2, 12'h0F0), 5'd14, 32'h0000_00F0);
        legal_row(i_word(3'b110, 5'd15, 5'd1, 12'h800), 5'd15, 32'hFFFF_F805);
        legal_row(i_word(3'b100, 5'd16, 5'd1, 12'hFFF), 5'd16, 32'hFFFF_FFFA);
        legal_row(i_word(3'b010, 5'd17, 5'd2, 12'hFFE), 5'd17, 32'd1);        // -3 < -2
        legal_row(i_word(3'b010, 5'd18, 5'd1, 12'd5), 5'd18, 32'd0);
        // Dependency chains at distance 1, 2 and across a bubble
        legal_row(i_word(3'b000, 5'd20, 5'd0, 12'd100), 5'd20, 32'd100);
        legal_row(i_word(3'b000, 5'd21, 5'd20, 12'd1), 5'd21, 32'd101);
        legal_row(r_word(7'h00, 3'b000, 5'd22, 5'd20, 5'd21), 5'd22, 32'd201);
        legal_row(r_word(7'h20, 3'b000, 5'd23, 5'd22, 5'd20), 5'd23, 32'd101);
        bubble_row(i_word(3'b000, 5'd23, 5'd0, 12'd7));
        legal_row(r_word(7'h00, 3'b000, 5'd24, 5'd23, 5'd22), 5'd24, 32'd302);
        // x0 and never written registers
        legal_row(i_word(3'b000, 5'd0, 5'd1, 12'd7), 5'd0, 32'd12);
        legal_row(r_word(7'h00, 3'b000, 5'd25, 5'd0, 5'd1), 5'd25, 32'd5);
        legal_row(r_word(7'h00, 3'b000, 5'd26, 5'd30, 5'd31), 5'd26, 32'd0);
        // Illegal encodings, destinations keep old values
        illegal_row({7'h00, 5'd2, 5'd1, 3'b000, 5'd1, 7'b1111111}, 5'd1);
        illegal_row(r_word(7'h01, 3'b000, 5'd1, 5'd1, 5'd2), 5'd1);
        illegal_row(r_word(7'h20, 3'b110, 5'd2, 5'd1, 5'd1), 5'd2);
        legal_row(r_word(7'h00, 3'b000, 5'd27, 5'd1, 5'd0), 5'd27, 32'd5);
        legal_row(r_word(7'h00, 3'b000, 5'd28, 5'd2, 5'd0), 5'd28, 32'hFFFF_FFFD);
        illegal_row(i_word(3'b001, 5'd3, 5'd1, 12'd2), 5'd3);               // SLLI
        illegal_row(r_word(7'h00, 3'b011, 5'd4, 5'd1, 5'd2), 5'd4);         // SLTU
        legal_row(r_word(7'h00, 3'b100, 5'd29, 5'd3, 5'd4), 5'd29, 32'd38);
        bubble_row(i_word(3'b000, 5'd8, 5'd0, 12'd1));
        bubble_row(i_word(3'b000, 5'd7, 5'd0, 12'd1));
        legal_row(r_word(7'h00, 3'b010, 5'd31, 5'd8, 5'd7), 5'd31, 32'd1);   // -8 < -3
    endtask

    task automatic apply_row(input int idx);
        row_t row;
        row                 = stim_rows[idx];
        fetch.valid         = row.valid;
        fetch.pc            = idx * 4;
        fetch.inst          = row.inst;
        exp_valid           = row.valid;
        exp_commit.valid    = 1'b1;
        exp_commit.pc       = idx * 4;
        exp_commit.rd       = row.rd;
        exp_commit.data     = row.data;
        exp_commit.write_en = row.write_en;
        exp_commit.illegal  = row.illegal;
    endtask

    //////////////////////////////////////////////////////////////////////
    // Run control
    //////////////////////////////////////////////////////////////////////

    // Hang guard, scaled to the table
    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= stim_rows.size() + 20) begin
            $display("Timeout: run did not finish within %0d cycles", cycle_count);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        clock       = 1'b0;
        reset       = 1'b1;
        fetch       = '0;
        exp_valid   = 1'b0;
        exp_commit  = '0;
        end_check   = 1'b0;
        cycle_count = 0;
        valid_rows  = 32'd0;
        build_table();
        foreach (stim_rows[i]) begin
            if (stim_rows[i].valid) valid_rows = valid_rows + 32'd1;
        end
        repeat (4) @(posedge clock);
        #1 reset = 1'b0;
        for (int i = 0; i < stim_rows.size(); i++) begin
            @(posedge clock);
            #1 apply_row(i);
        end
        @(posedge clock);
        #1;
        fetch.valid = 1'b0;
        exp_valid   = 1'b0;
        repeat (3) @(posedge clock);  // Last commit trails fetch by 2
        #1 end_check = 1'b1;
        wait (check_done);
        if (error_total == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- sim.f
rtl/core_pkg.sv
rtl/regfile.sv
rtl/stage_decode.sv
rtl/stage_execute.sv
rtl/stage_result.sv
rtl/core_top.sv
tests/core_asserts.sv
tests/core_checker.sv
tests/core_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module core_tb -f sim.f -o Vcore_tb
	./obj_dir/Vcore_tb | tee $(LOG)
	grep -q "all tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
